// ==== gat_config.svh ====
`ifndef GAT_CONFIG_SVH
`define GAT_CONFIG_SVH

// Element width of W, values and WH
`define DATA_W      16

// Feature sizes
`define F_IN        8
`define F_OUT       2

// Nodes per subgraph, target node in slot 0
`define MAX_NODES   4

// Memory address widths
`define NNZ_AW      6
`define ROW_AW      5

`define FIFO_DEPTH  4

// Score to exponent mapping
`define SCORE_SHIFT 4
`define EXP_MAX     7

// Fraction bits of an attention weight
`define ALPHA_FRAC  8

`endif

// ==== gat_pkg.sv ====
`include "gat_config.svh"

package gat_pkg;

  typedef logic [`F_OUT-1:0][`DATA_W-1:0] wh_t;

  typedef struct packed {
    logic [3:0] nnz;
    logic       last_in_sub;
    logic       last_in_graph;
  } node_info_t;

  typedef logic [2:0] cnt_t;

  typedef logic [`MAX_NODES-1:0][2:0] exp_vec_t;
  typedef logic [`MAX_NODES-1:0][8:0] alpha_vec_t;
  typedef wh_t  [`MAX_NODES-1:0]      wh_set_t;

  typedef enum logic [2:0] {S_IDLE, S_INFO, S_MAC, S_EMIT, S_DONE} spmm_state_t;

  typedef enum logic [1:0] {SM_IDLE, SM_SUM, SM_DIV, SM_PUSH} sm_state_t;

  typedef enum logic [1:0] {AG_IDLE, AG_ACC, AG_OUT} ag_state_t;

endpackage

// ==== sdp_ram.sv ====
`timescale 1ns/100ps

module sdp_ram #(
  parameter int AW = 4,
  parameter int DW = 8
) (
  input  logic          clk,
  input  logic          we_i,
  input  logic [AW-1:0] waddr_i,
  input  logic [DW-1:0] din_i,
  input  logic [AW-1:0] raddr_i,
  output logic [DW-1:0] dout_o
);

  logic [DW-1:0] mem [2**AW];

  // Host write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= din_i;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    dout_o <= mem[raddr_i];
  end

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
  parameter int DW    = 8,
  parameter int DEPTH = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          push_i,
  input  logic [DW-1:0] din_i,
  input  logic          pop_i,
  output logic [DW-1:0] dout_o,
  output logic          full_o,
  output logic          empty_o
);

  localparam int AW = $clog2(DEPTH);

  logic [DW-1:0] mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign full_o  = (count == (AW+1)'(DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head word is always visible
  assign dout_o = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din_i;
    end
  end

endmodule

// ==== spmm.sv ====
`timescale 1ns/100ps
`include "gat_config.svh"

module spmm import gat_pkg::*; #(
  parameter int COL_W = $clog2(`F_IN)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load_done_i,
  input  logic               stall_i,
  input  node_info_t         info_i,
  input  logic [COL_W-1:0]   col_i,
  input  logic [`DATA_W-1:0] val_i,
  input  wh_t                w_i,
  output logic [`ROW_AW-1:0] info_addr_o,
  output logic [`NNZ_AW-1:0] nnz_addr_o,
  output logic [COL_W-1:0]   w_addr_o,
  output logic               wh_valid_o,
  output wh_t                wh_o,
  output logic               last_sub_o,
  output logic               last_graph_o
);

  spmm_state_t        state;
  logic               ld_q;
  logic               ld_rise;
  logic [`ROW_AW-1:0] row_q;
  logic [`NNZ_AW-1:0] ptr_q;
  logic [3:0]         left_q;
  logic               lsub_q;
  logic               lgraph_q;
  logic               mac_v;
  logic               wh_valid_q;
  logic [`DATA_W-1:0] val_d;
  wh_t                acc_q;

  assign ld_rise = load_done_i & ~ld_q;

  // Next address goes out so RAM data matches row_q and ptr_q
  assign info_addr_o = (state == S_EMIT) ? row_q + 1'b1 : row_q;
  assign nnz_addr_o  = (state == S_MAC) ? ptr_q + 1'b1 : ptr_q;
  assign w_addr_o    = col_i;

  assign wh_valid_o   = wh_valid_q;
  assign wh_o         = acc_q;
  assign last_sub_o   = lsub_q;
  assign last_graph_o = lgraph_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      ld_q       <= 1'b0;
      row_q      <= '0;
      ptr_q      <= '0;
      left_q     <= '0;
      lsub_q     <= 1'b0;
      lgraph_q   <= 1'b0;
      mac_v      <= 1'b0;
      wh_valid_q <= 1'b0;
    end else begin
      ld_q       <= load_done_i;
      mac_v      <= (state == S_MAC);
      wh_valid_q <= (state == S_EMIT);
      row_q      <= info_addr_o;
      ptr_q      <= nnz_addr_o;
      case (state)
        S_IDLE: begin
          if (ld_rise) begin
            state <= S_INFO;
          end
        end
        S_INFO: begin
          if (!stall_i) begin
            left_q   <= info_i.nnz;
            lsub_q   <= info_i.last_in_sub;
            lgraph_q <= info_i.last_in_graph;
            state    <= (info_i.nnz == '0) ? S_EMIT : S_MAC;
          end
        end
        S_MAC: begin
          left_q <= left_q - 1'b1;
          if (left_q == 4'd1) begin
            state <= S_EMIT;
          end
        end
        S_EMIT: begin
          state <= lgraph_q ? S_DONE : S_INFO;
        end
        default: begin
          row_q <= '0;
          ptr_q <= '0;
          if (!load_done_i) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Value waits one cycle for its weight row
  always_ff @(posedge clk) begin
    val_d <= val_i;
    if (state == S_INFO) begin
      acc_q <= '0;
    end else if (mac_v) begin
      for (int k = 0; k < `F_OUT; k++) begin
        // Wraps to 16 bits
        acc_q[k] <= acc_q[k] + val_d * w_i[k];
      end
    end
  end

endmodule

// ==== dmvm.sv ====
`timescale 1ns/100ps
`include "gat_config.svh"

module dmvm import gat_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       attn_we_i,
  input  logic       attn_sel_i,
  input  wh_t        attn_din_i,
  input  logic       wh_valid_i,
  input  wh_t        wh_i,
  input  logic       last_sub_i,
  input  logic       last_graph_i,
  input  logic       exp_full_i,
  input  logic       wh_full_i,
  output logic       stall_o,
  output logic       push_o,
  output exp_vec_t   exp_o,
  output cnt_t       cnt_o,
  output logic       last_graph_o,
  output wh_set_t    wh_set_o
);

  wh_t                a_self_q;
  wh_t                a_nbr_q;
  logic signed [35:0] self_q;
  logic signed [35:0] self_cur;
  logic signed [35:0] score;
  logic signed [35:0] leaky;
  logic signed [35:0] shifted;
  logic [2:0]         e_new;
  logic [1:0]         idx_q;
  logic               pend_q;
  logic               lg_q;
  cnt_t               cnt_q;
  exp_vec_t           exp_q;
  wh_set_t            set_q;

  function automatic logic signed [35:0] dot(input wh_t a, input wh_t b);
    logic signed [35:0] s;
    s = '0;
    for (int k = 0; k < `F_OUT; k++) begin
      s += $signed(a[k]) * $signed(b[k]);
    end
    return s;
  endfunction

  // Slot 0 is the target, its a_self term is reused for the neighbors
  always_comb begin
    self_cur = (idx_q == 2'd0) ? dot(a_self_q, wh_i) : self_q;
    score    = self_cur + dot(a_nbr_q, wh_i);
    leaky    = score[35] ? score >>> 3 : score;
    shifted  = leaky >>> `SCORE_SHIFT;
    if (shifted < 0) begin
      e_new = 3'd0;
    end else if (shifted > `EXP_MAX) begin
      e_new = 3'(`EXP_MAX);
    end else begin
      e_new = shifted[2:0];
    end
  end

  assign stall_o      = pend_q | (wh_valid_i & last_sub_i);
  assign push_o       = pend_q & ~exp_full_i & ~wh_full_i;
  assign exp_o        = exp_q;
  assign cnt_o        = cnt_q;
  assign last_graph_o = lg_q;
  assign wh_set_o     = set_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      if (wh_valid_i) begin
        if (last_sub_i) begin
          pend_q <= 1'b1;
          idx_q  <= '0;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
      if (push_o) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (attn_we_i) begin
      if (attn_sel_i) begin
        a_nbr_q <= attn_din_i;
      end else begin
        a_self_q <= attn_din_i;
      end
    end
    if (wh_valid_i) begin
      exp_q[idx_q] <= e_new;
      set_q[idx_q] <= wh_i;
      if (idx_q == 2'd0) begin
        self_q <= self_cur;
      end
      if (last_sub_i) begin
        cnt_q <= {1'b0, idx_q} + 3'd1;
        lg_q  <= last_graph_i;
      end
    end
  end

endmodule

// ==== softmax.sv ====
`timescale 1ns/100ps
`include "gat_config.svh"

module softmax import gat_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       empty_i,
  input  exp_vec_t   exp_i,
  input  cnt_t       cnt_i,
  input  logic       last_graph_i,
  input  logic       full_i,
  output logic       pop_o,
  output logic       push_o,
  output alpha_vec_t alpha_o,
  output cnt_t       cnt_o,
  output logic       last_graph_o
);

  sm_state_t  state;
  exp_vec_t   exp_q;
  cnt_t       cnt_q;
  logic       lg_q;
  alpha_vec_t alpha_q;
  logic [9:0] den_q;
  logic [9:0] rem_q;
  logic [8:0] nlo_q;
  logic [7:0] q_q;
  logic [3:0] bi_q;
  logic [1:0] j_q;
  logic       ld_q;
  logic [9:0] sum_c;
  logic [15:0] num_c;
  logic [10:0] trial;
  logic        ge;

  always_comb begin
    sum_c = '0;
    for (int j = 0; j < `MAX_NODES; j++) begin
      if (j < int'(cnt_q)) begin
        sum_c = sum_c + (10'd1 << exp_q[j]);
      end
    end
    num_c = 16'd1 << (exp_q[j_q] + 4'(`ALPHA_FRAC));
    // Restoring step for one quotient bit per cycle
    trial = {rem_q, nlo_q[8]};
    ge    = (trial >= {1'b0, den_q});
  end

  assign pop_o        = (state == SM_IDLE) & ~empty_i;
  assign push_o       = (state == SM_PUSH) & ~full_i;
  assign alpha_o      = alpha_q;
  assign cnt_o        = cnt_q;
  assign last_graph_o = lg_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SM_IDLE;
      j_q   <= '0;
      bi_q  <= '0;
      ld_q  <= 1'b0;
    end else begin
      case (state)
        SM_IDLE: begin
          if (pop_o) begin
            state <= SM_SUM;
          end
        end
        SM_SUM: begin
          state <= SM_DIV;
          j_q   <= '0;
          ld_q  <= 1'b1;
        end
        SM_DIV: begin
          if (ld_q) begin
            ld_q <= 1'b0;
            bi_q <= 4'd8;
          end else if (bi_q == '0) begin
            ld_q <= 1'b1;
            if ({1'b0, j_q} == cnt_q - 3'd1) begin
              state <= SM_PUSH;
            end else begin
              j_q <= j_q + 1'b1;
            end
          end else begin
            bi_q <= bi_q - 1'b1;
          end
        end
        default: begin
          if (!full_i) begin
            state <= SM_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      exp_q <= exp_i;
      cnt_q <= cnt_i;
      lg_q  <= last_graph_i;
    end
    if (state == SM_SUM) begin
      den_q   <= sum_c;
      alpha_q <= '0;
    end
    if (state == SM_DIV) begin
      if (ld_q) begin
        // Quotient fits in 9 bits, so start from the upper dividend bits
        rem_q <= 10'(num_c[15:9]);
        nlo_q <= num_c[8:0];
      end else begin
        rem_q <= ge ? 10'(trial - {1'b0, den_q}) : trial[9:0];
        nlo_q <= {nlo_q[7:0], 1'b0};
        q_q   <= {q_q[6:0], ge};
        if (bi_q == '0) begin
          alpha_q[j_q] <= {q_q, ge};
        end
      end
    end
  end

endmodule

// ==== aggregator.sv ====
`timescale 1ns/100ps
`include "gat_config.svh"

module aggregator import gat_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       alpha_empty_i,
  input  logic       wh_empty_i,
  input  alpha_vec_t alpha_i,
  input  wh_set_t    wh_set_i,
  input  cnt_t       cnt_i,
  input  logic       last_graph_i,
  output logic       pop_o,
  output logic       out_valid_o,
  output wh_t        out_o,
  output logic       graph_done_o
);

  ag_state_t          state;
  alpha_vec_t         al_q;
  wh_set_t            set_q;
  cnt_t               cnt_q;
  logic               lg_q;
  logic [1:0]         j_q;
  logic signed [31:0] acc_q [`F_OUT];

  assign pop_o        = (state == AG_IDLE) & ~alpha_empty_i & ~wh_empty_i;
  assign out_valid_o  = (state == AG_OUT);
  assign graph_done_o = out_valid_o & lg_q;

  always_comb begin
    logic signed [31:0] sh;
    for (int k = 0; k < `F_OUT; k++) begin
      sh       = acc_q[k] >>> `ALPHA_FRAC;
      out_o[k] = sh[`DATA_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= AG_IDLE;
      j_q   <= '0;
    end else begin
      case (state)
        AG_IDLE: begin
          if (pop_o) begin
            state <= AG_ACC;
            j_q   <= '0;
          end
        end
        AG_ACC: begin
          if ({1'b0, j_q} == cnt_q - 3'd1) begin
            state <= AG_OUT;
          end else begin
            j_q <= j_q + 1'b1;
          end
        end
        default: state <= AG_IDLE;
      endcase
    end
  end

  // One neighbor per cycle
  always_ff @(posedge clk) begin
    if (pop_o) begin
      al_q  <= alpha_i;
      set_q <= wh_set_i;
      cnt_q <= cnt_i;
      lg_q  <= last_graph_i;
      for (int k = 0; k < `F_OUT; k++) begin
        acc_q[k] <= '0;
      end
    end else if (state == AG_ACC) begin
      for (int k = 0; k < `F_OUT; k++) begin
        acc_q[k] <= acc_q[k] + $signed({1'b0, al_q[j_q]}) * $signed(set_q[j_q][k]);
      end
    end
  end

endmodule

// ==== gat_top.sv ====
`timescale 1ns/100ps
`include "gat_config.svh"

module gat_top import gat_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      load_done_i,
  input  logic                      col_we_i,
  input  logic [`NNZ_AW-1:0]        col_addr_i,
  input  logic [$clog2(`F_IN)-1:0]  col_din_i,
  input  logic                      val_we_i,
  input  logic [`NNZ_AW-1:0]        val_addr_i,
  input  logic [`DATA_W-1:0]        val_din_i,
  input  logic                      info_we_i,
  input  logic [`ROW_AW-1:0]        info_addr_i,
  input  node_info_t                info_din_i,
  input  logic                      w_we_i,
  input  logic [$clog2(`F_IN)-1:0]  w_addr_i,
  input  wh_t                       w_din_i,
  input  logic                      attn_we_i,
  input  logic                      attn_sel_i,
  input  wh_t                       attn_din_i,
  output logic                      out_valid_o,
  output wh_t                       out_o,
  output logic                      graph_done_o
);

  localparam int COL_W  = $clog2(`F_IN);
  localparam int EXP_FW = $bits(exp_vec_t) + $bits(cnt_t) + 1;
  localparam int WH_FW  = $bits(wh_set_t) + $bits(cnt_t);
  localparam int AL_FW  = $bits(alpha_vec_t) + $bits(cnt_t) + 1;

  logic [`ROW_AW-1:0] info_raddr;
  logic [`NNZ_AW-1:0] nnz_raddr;
  logic [COL_W-1:0]   w_raddr;
  node_info_t         info_dout;
  logic [COL_W-1:0]   col_dout;
  logic [`DATA_W-1:0] val_dout;
  wh_t                w_dout;

  logic               wh_valid;
  wh_t                wh;
  logic               last_sub;
  logic               last_graph;
  logic               dmvm_stall;

  logic               dm_push;
  exp_vec_t           dm_exp;
  cnt_t               dm_cnt;
  logic               dm_lg;
  wh_set_t            dm_set;

  logic               ef_pop;
  logic               ef_full;
  logic               ef_empty;
  exp_vec_t           ef_exp;
  cnt_t               ef_cnt;
  logic               ef_lg;

  logic               wf_full;
  logic               wf_empty;
  logic [WH_FW-1:0]   wf_dout;

  logic               sm_push;
  alpha_vec_t         sm_alpha;
  cnt_t               sm_cnt;
  logic               sm_lg;
  logic               af_full;
  logic               af_empty;
  alpha_vec_t         af_alpha;
  cnt_t               af_cnt;
  logic               af_lg;
  logic               ag_pop;

  sdp_ram #(.AW(`NNZ_AW), .DW(COL_W)) col_ram_i (
    .clk(clk), .we_i(col_we_i), .waddr_i(col_addr_i), .din_i(col_din_i),
    .raddr_i(nnz_raddr), .dout_o(col_dout)
  );

  sdp_ram #(.AW(`NNZ_AW), .DW(`DATA_W)) val_ram_i (
    .clk(clk), .we_i(val_we_i), .waddr_i(val_addr_i), .din_i(val_din_i),
    .raddr_i(nnz_raddr), .dout_o(val_dout)
  );

  sdp_ram #(.AW(`ROW_AW), .DW($bits(node_info_t))) info_ram_i (
    .clk(clk), .we_i(info_we_i), .waddr_i(info_addr_i), .din_i(info_din_i),
    .raddr_i(info_raddr), .dout_o(info_dout)
  );

  sdp_ram #(.AW(COL_W), .DW($bits(wh_t))) w_ram_i (
    .clk(clk), .we_i(w_we_i), .waddr_i(w_addr_i), .din_i(w_din_i),
    .raddr_i(w_raddr), .dout_o(w_dout)
  );

  spmm #(.COL_W(COL_W)) spmm_i (
    .clk(clk), .rst_n(rst_n), .load_done_i(load_done_i), .stall_i(dmvm_stall),
    .info_i(info_dout), .col_i(col_dout), .val_i(val_dout), .w_i(w_dout),
    .info_addr_o(info_raddr), .nnz_addr_o(nnz_raddr), .w_addr_o(w_raddr),
    .wh_valid_o(wh_valid), .wh_o(wh), .last_sub_o(last_sub), .last_graph_o(last_graph)
  );

  dmvm dmvm_i (
    .clk(clk), .rst_n(rst_n), .attn_we_i(attn_we_i), .attn_sel_i(attn_sel_i),
    .attn_din_i(attn_din_i), .wh_valid_i(wh_valid), .wh_i(wh), .last_sub_i(last_sub),
    .last_graph_i(last_graph), .exp_full_i(ef_full), .wh_full_i(wf_full),
    .stall_o(dmvm_stall), .push_o(dm_push), .exp_o(dm_exp), .cnt_o(dm_cnt),
    .last_graph_o(dm_lg), .wh_set_o(dm_set)
  );

  sync_fifo #(.DW(EXP_FW), .DEPTH(`FIFO_DEPTH)) exp_fifo_i (
    .clk(clk), .rst_n(rst_n), .push_i(dm_push), .din_i({dm_exp, dm_cnt, dm_lg}),
    .pop_i(ef_pop), .dout_o({ef_exp, ef_cnt, ef_lg}), .full_o(ef_full), .empty_o(ef_empty)
  );

  // Count rides along with the alpha vector too
  sync_fifo #(.DW(WH_FW), .DEPTH(`FIFO_DEPTH)) wh_fifo_i (
    .clk(clk), .rst_n(rst_n), .push_i(dm_push), .din_i({dm_set, dm_cnt}),
    .pop_i(ag_pop), .dout_o(wf_dout), .full_o(wf_full), .empty_o(wf_empty)
  );

  softmax softmax_i (
    .clk(clk), .rst_n(rst_n), .empty_i(ef_empty), .exp_i(ef_exp), .cnt_i(ef_cnt),
    .last_graph_i(ef_lg), .full_i(af_full), .pop_o(ef_pop), .push_o(sm_push),
    .alpha_o(sm_alpha), .cnt_o(sm_cnt), .last_graph_o(sm_lg)
  );

  sync_fifo #(.DW(AL_FW), .DEPTH(`FIFO_DEPTH)) alpha_fifo_i (
    .clk(clk), .rst_n(rst_n), .push_i(sm_push), .din_i({sm_alpha, sm_cnt, sm_lg}),
    .pop_i(ag_pop), .dout_o({af_alpha, af_cnt, af_lg}), .full_o(af_full),
    .empty_o(af_empty)
  );

  aggregator aggregator_i (
    .clk(clk), .rst_n(rst_n), .alpha_empty_i(af_empty), .wh_empty_i(wf_empty),
    .alpha_i(af_alpha), .wh_set_i(wf_dout[WH_FW-1 -: $bits(wh_set_t)]), .cnt_i(af_cnt),
    .last_graph_i(af_lg), .pop_o(ag_pop), .out_valid_o(out_valid_o), .out_o(out_o),
    .graph_done_o(graph_done_o)
  );

endmodule

// ==== tb_gat_top.sv ====
`timescale 1ns/100ps
`include "gat_config.svh"

module tb_gat_top import gat_pkg::*; ();

  localparam int DW      = `DATA_W;
  localparam int COL_W   = $clog2(`F_IN);
  localparam int NNZ_N   = 2**`NNZ_AW;
  localparam int ROW_N   = 2**`ROW_AW;
  localparam int N_CASES = 6;
  localparam int TIMEOUT = 1000;
  localparam int QUIET   = 20;

  // Row count, last_in_sub per row, nnz per row with row 0 in the low nibble
  localparam int          CASE_ROWS [N_CASES] = '{1, 2, 4, 6, 12, 8};
  localparam logic [15:0] CASE_SUB  [N_CASES] = '{16'h1, 16'h3, 16'h8, 16'h34, 16'hd9d, 16'h88};
  localparam logic [63:0] CASE_NNZ  [N_CASES] = '{64'h3, 64'h8f, 64'h4132, 64'hf0_2050,
                                                  64'h2222_2222_2222, 64'h5603_2714};
  // Signed widths of H values and W, then of the attention vectors
  localparam int          CASE_VB   [N_CASES] = '{16, 16, 3, 3, 3, 16};
  localparam int          CASE_AB   [N_CASES] = '{16, 16, 2, 2, 2, 16};

  logic                 clk;
  logic                 rst_n;
  logic                 load_done_i;
  logic                 col_we_i;
  logic [`NNZ_AW-1:0]   col_addr_i;
  logic [COL_W-1:0]     col_din_i;
  logic                 val_we_i;
  logic [`NNZ_AW-1:0]   val_addr_i;
  logic [`DATA_W-1:0]   val_din_i;
  logic                 info_we_i;
  logic [`ROW_AW-1:0]   info_addr_i;
  node_info_t           info_din_i;
  logic                 w_we_i;
  logic [COL_W-1:0]     w_addr_i;
  wh_t                  w_din_i;
  logic                 attn_we_i;
  logic                 attn_sel_i;
  wh_t                  attn_din_i;
  logic                 out_valid_o;
  wh_t                  out_o;
  logic                 graph_done_o;

  logic [COL_W-1:0]     col_tab [NNZ_N];
  logic [`DATA_W-1:0]   val_tab [NNZ_N];
  node_info_t           info_tab [ROW_N];
  wh_t                  w_tab [`F_IN];
  wh_t                  wh_ref [ROW_N];
  wh_t                  a_self;
  wh_t                  a_nbr;
  wh_t                  exp_out_q [$];
  logic                 exp_done_q [$];
  logic [31:0]          lfsr;

  gat_top gat_top_i (
    .clk(clk), .rst_n(rst_n), .load_done_i(load_done_i),
    .col_we_i(col_we_i), .col_addr_i(col_addr_i), .col_din_i(col_din_i),
    .val_we_i(val_we_i), .val_addr_i(val_addr_i), .val_din_i(val_din_i),
    .info_we_i(info_we_i), .info_addr_i(info_addr_i), .info_din_i(info_din_i),
    .w_we_i(w_we_i), .w_addr_i(w_addr_i), .w_din_i(w_din_i),
    .attn_we_i(attn_we_i), .attn_sel_i(attn_sel_i), .attn_din_i(attn_din_i),
    .out_valid_o(out_valid_o), .out_o(out_o), .graph_done_o(graph_done_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit drawn
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  function automatic logic [`DATA_W-1:0] rand_signed(int bits);
    logic [31:0] r;
    r = take_bits(bits);
    if (r[bits-1]) begin
      r = r | ~((32'd1 << bits) - 32'd1);
    end
    return r[`DATA_W-1:0];
  endfunction

  function automatic longint dot_signed(wh_t a, wh_t b);
    longint s;
    s = 0;
    for (int k = 0; k < `F_OUT; k++) begin
      s += longint'($signed(a[k])) * longint'($signed(b[k]));
    end
    return s;
  endfunction

  // WH of one row, full signed sum then wrapped to 16 bits
  function automatic wh_t row_wh(int start, int nnz);
    longint sum [`F_OUT];
    wh_t    res;
    for (int k = 0; k < `F_OUT; k++) begin
      sum[k] = 0;
    end
    for (int p = start; p < start + nnz; p++) begin
      for (int k = 0; k < `F_OUT; k++) begin
        sum[k] += longint'($signed(val_tab[p])) * longint'($signed(w_tab[col_tab[p]][k]));
      end
    end
    for (int k = 0; k < `F_OUT; k++) begin
      res[k] = DW'(sum[k]);
    end
    return res;
  endfunction

  // Leaky score, clamped exponent, floor division and weighted sum
  function automatic wh_t subgraph_out(int first, int cnt);
    longint score;
    longint tself;
    longint sum;
    longint alpha;
    longint acc [`F_OUT];
    int     e [`MAX_NODES];
    wh_t    res;
    tself = dot_signed(a_self, wh_ref[first]);
    sum = 0;
    for (int j = 0; j < cnt; j++) begin
      score = tself + dot_signed(a_nbr, wh_ref[first + j]);
      if (score < 0) begin
        score = score >>> 3;
      end
      score = score >>> `SCORE_SHIFT;
      if (score < 0) begin
        e[j] = 0;
      end else if (score > `EXP_MAX) begin
        e[j] = `EXP_MAX;
      end else begin
        e[j] = int'(score);
      end
      sum += longint'(1) << e[j];
    end
    for (int k = 0; k < `F_OUT; k++) begin
      acc[k] = 0;
    end
    for (int j = 0; j < cnt; j++) begin
      alpha = (longint'(1) << (e[j] + `ALPHA_FRAC)) / sum;
      for (int k = 0; k < `F_OUT; k++) begin
        acc[k] += alpha * longint'($signed(wh_ref[first + j][k]));
      end
    end
    for (int k = 0; k < `F_OUT; k++) begin
      res[k] = DW'(acc[k] >>> `ALPHA_FRAC);
    end
    return res;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic fail_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_out(wh_t got, wh_t exp, int c, int n);
    if (got !== exp) begin
      $display("MISMATCH at %0t: case %0d result %0d out_o %h, expected %h",
               $time, c, n, got, exp);
      fail_run();
    end
  endtask

  task automatic check_done(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic build_case(int c);
    node_info_t ni;
    for (int i = 0; i < `F_IN; i++) begin
      for (int k = 0; k < `F_OUT; k++) begin
        w_tab[i][k] = rand_signed(CASE_VB[c]);
      end
    end
    for (int k = 0; k < `F_OUT; k++) begin
      a_self[k] = rand_signed(CASE_AB[c]);
      a_nbr[k]  = rand_signed(CASE_AB[c]);
    end
    for (int i = 0; i < NNZ_N; i++) begin
      col_tab[i] = COL_W'(take_bits(COL_W));
      val_tab[i] = rand_signed(CASE_VB[c]);
    end
    for (int r = 0; r < ROW_N; r++) begin
      ni = '0;
      if (r < CASE_ROWS[c]) begin
        ni.nnz           = CASE_NNZ[c][4*r +: 4];
        ni.last_in_sub   = CASE_SUB[c][r];
        ni.last_in_graph = (r == CASE_ROWS[c] - 1);
      end
      info_tab[r] = ni;
    end
  endtask

  task automatic expect_case(int c);
    int p;
    int first;
    p = 0;
    first = 0;
    for (int r = 0; r < CASE_ROWS[c]; r++) begin
      wh_ref[r] = row_wh(p, int'(info_tab[r].nnz));
      p += int'(info_tab[r].nnz);
      if (info_tab[r].last_in_sub) begin
        exp_out_q.push_back(subgraph_out(first, r - first + 1));
        exp_done_q.push_back(r == CASE_ROWS[c] - 1);
        first = r + 1;
      end
    end
  endtask

  // All four tables and both attention vectors in one sweep
  task automatic load_case();
    for (int i = 0; i < NNZ_N; i++) begin
      col_we_i    = 1'b1;
      col_addr_i  = `NNZ_AW'(i);
      col_din_i   = col_tab[i];
      val_we_i    = 1'b1;
      val_addr_i  = `NNZ_AW'(i);
      val_din_i   = val_tab[i];
      info_we_i   = (i < ROW_N);
      info_addr_i = `ROW_AW'(i);
      info_din_i  = info_tab[i % ROW_N];
      w_we_i      = (i < `F_IN);
      w_addr_i    = COL_W'(i);
      w_din_i     = w_tab[i % `F_IN];
      attn_we_i   = (i < 2);
      attn_sel_i  = (i == 1);
      attn_din_i  = (i == 1) ? a_nbr : a_self;
      next_cycle();
    end
    col_we_i  = 1'b0;
    val_we_i  = 1'b0;
    info_we_i = 1'b0;
    w_we_i    = 1'b0;
    attn_we_i = 1'b0;
  endtask

  task automatic collect_results(int c);
    int n;
    int idle;
    n = 0;
    idle = 0;
    while (exp_out_q.size() > 0) begin
      @(negedge clk);
      if (out_valid_o) begin
        check_out(out_o, exp_out_q.pop_front(), c, n);
        check_done(graph_done_o, exp_done_q.pop_front(), "graph_done_o");
        n++;
        idle = 0;
      end else begin
        check_done(graph_done_o, 1'b0, "graph_done_o");
        idle++;
        if (idle > TIMEOUT) begin
          $display("Timeout in case %0d: only %0d results arrived", c, n);
          fail_run();
        end
      end
    end
    // No extra result after the last one
    for (int i = 0; i < QUIET; i++) begin
      @(negedge clk);
      check_done(out_valid_o, 1'b0, "out_valid_o");
      check_done(graph_done_o, 1'b0, "graph_done_o");
    end
  endtask

  task automatic run_case(int c);
    build_case(c);
    expect_case(c);
    load_case();
    repeat (3) next_cycle();
    load_done_i = 1'b1;
    collect_results(c);
    next_cycle();
    load_done_i = 1'b0;
    next_cycle();
  endtask

  initial begin
    lfsr        = 32'hea11_d30d;
    rst_n       = 1'b0;
    load_done_i = 1'b0;
    col_we_i    = 1'b0;
    col_addr_i  = '0;
    col_din_i   = '0;
    val_we_i    = 1'b0;
    val_addr_i  = '0;
    val_din_i   = '0;
    info_we_i   = 1'b0;
    info_addr_i = '0;
    info_din_i  = '0;
    w_we_i      = 1'b0;
    w_addr_i    = '0;
    w_din_i     = '0;
    attn_we_i   = 1'b0;
    attn_sel_i  = 1'b0;
    attn_din_i  = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Quiet outputs with no load
    for (int i = 0; i < QUIET; i++) begin
      @(negedge clk);
      check_done(out_valid_o, 1'b0, "out_valid_o after reset");
      check_done(graph_done_o, 1'b0, "graph_done_o after reset");
    end
    next_cycle();
    for (int c = 0; c < N_CASES; c++) begin
      run_case(c);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
gat_pkg.sv
sdp_ram.sv
sync_fifo.sv
spmm.sv
dmvm.sv
softmax.sv
aggregator.sv
gat_top.sv
tb_gat_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= tb_gat_top
FILELIST  ?= compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir
